//--- source/lc_consts.svh
`ifndef LC_CONSTS_SVH
`define LC_CONSTS_SVH

// Bus word sizes
`define MBUS_ADDR_WIDTH 32
`define MBUS_DATA_WIDTH 32
`define FUNC_WIDTH 4

// Register file geometry
`define LC_RF_DATA_WIDTH 24
`define LC_RF_DEPTH 8
`define LC_RF_IDX_WIDTH 3

// Word memory geometry
`define LC_MEM_ADDR_WIDTH 6
`define LC_MEM_DEPTH 64
`define LC_MEM_DATA_WIDTH 32

// Function codes in the low receive address bits
`define LC_CMD_RF_READ 4'd0
`define LC_CMD_RF_WRITE 4'd1
`define LC_CMD_MEM_READ 4'd2
`define LC_CMD_MEM_WRITE 4'd3
`define LC_CMD_MEM_DMA_WRITE 4'd5

// Function field on replies and events
`define CHANNEL_MEMBER_EVENT 1

`endif

//--- source/mbus_pkg.sv
`include "lc_consts.svh"

package mbus_pkg;

	// Full bus address word
	typedef logic [`MBUS_ADDR_WIDTH-1:0] mbus_addr_t;

	// Full bus data word
	typedef logic [`MBUS_DATA_WIDTH-1:0] mbus_data_t;

	// Function field, also the width of the short address
	typedef logic [`FUNC_WIDTH-1:0] func_id_t;

endpackage

//--- source/layer_pkg.sv
`include "lc_consts.svh"

package layer_pkg;

	typedef logic [`LC_RF_DATA_WIDTH-1:0] rf_data_t;
	typedef logic [`LC_RF_IDX_WIDTH-1:0] rf_idx_t;
	// All registers side by side, register 0 in the low bits
	typedef logic [`LC_RF_DATA_WIDTH*`LC_RF_DEPTH-1:0] rf_bank_t;
	typedef logic [`LC_RF_DEPTH-1:0] rf_load_t;

	typedef logic [`LC_MEM_ADDR_WIDTH-1:0] mem_addr_t;
	typedef logic [`LC_MEM_DATA_WIDTH-1:0] mem_data_t;

	// Controller main states
	typedef enum logic [3:0] {
		st_idle,
		st_rf_read,
		st_rf_write,
		st_mem_read,
		st_mem_write,
		st_dma_write,
		st_bus_tx,
		st_wait_cpl,
		st_int
	} lc_state_t;

	// Steps inside a memory command
	typedef enum logic [1:0] {
		step_addr,
		step_data,
		step_req,
		step_ack
	} mem_step_t;

endpackage

//--- source/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if import layer_pkg::*; ();

	logic req;
	logic write;
	mem_addr_t addr;
	mem_data_t wdata;
	mem_data_t rdata;
	logic ack;

	// Requesting side
	modport ctrl (
		output req,
		output write,
		output addr,
		output wdata,
		input rdata,
		input ack
	);

	// Memory side
	modport mem (
		input req,
		input write,
		input addr,
		input wdata,
		output rdata,
		output ack
	);

endinterface

//--- source/layer_ctrl.sv
`timescale 1ns/1ps
`include "lc_consts.svh"

module layer_ctrl import mbus_pkg::*, layer_pkg::*; (
	input logic CLK,
	input logic MEM_ACK_RSTn,
	// Bus transmit side
	output mbus_addr_t tx_addr,
	output mbus_data_t tx_data,
	output logic tx_pend,
	output logic tx_req,
	input logic tx_ack,
	// Bus receive side
	input mbus_addr_t rx_addr,
	input mbus_data_t rx_data,
	input logic rx_pend,
	input logic rx_req,
	output logic rx_ack,
	input logic rx_fail,
	// Completion
	input logic tx_succ,
	input logic tx_fail,
	output logic tx_resp_ack,
	// Register file
	input rf_bank_t rf_din,
	output rf_data_t rf_dout,
	output rf_load_t rf_load,
	// Memory
	mem_port_if.ctrl mem,
	// Interrupt
	input logic interrupt,
	output logic clr_int,
	input func_id_t short_addr
);

	lc_state_t state;
	lc_state_t next_state;
	mem_step_t step;
	mem_step_t next_step;
	logic rx_pend_q;
	logic next_rx_pend;
	mbus_data_t rx_buf;
	mbus_data_t next_rx_buf;

	mbus_addr_t next_tx_addr;
	mbus_data_t next_tx_data;
	logic next_tx_req;
	logic next_rx_ack;
	logic next_tx_resp_ack;
	logic next_clr_int;
	rf_data_t next_rf_dout;
	rf_load_t next_rf_load;
	mem_addr_t next_mem_addr;
	mem_data_t next_mem_wdata;
	logic next_mem_req;
	logic next_mem_we;

	func_id_t rx_func;
	rf_idx_t rf_idx;
	logic rf_idx_ok;
	rf_data_t rf_rd_val;

	assign rx_func = rx_addr[`FUNC_WIDTH-1:0];
	// Index 8 and up aliases onto the low three bits
	assign rf_idx = rx_buf[`LC_RF_DATA_WIDTH +: `LC_RF_IDX_WIDTH];
	assign rf_idx_ok = (rx_buf[`MBUS_DATA_WIDTH-1:`LC_RF_DATA_WIDTH] < `LC_RF_DEPTH);
	assign rf_rd_val = rf_din[rf_idx*`LC_RF_DATA_WIDTH +: `LC_RF_DATA_WIDTH];

	// No multi-word replies
	assign tx_pend = 1'b0;

	always_ff @(posedge CLK or negedge MEM_ACK_RSTn)
	begin
		if (!MEM_ACK_RSTn)
		begin
			state <= st_idle;
			step <= step_addr;
			rx_pend_q <= 1'b0;
			tx_req <= 1'b0;
			rx_ack <= 1'b0;
			tx_resp_ack <= 1'b0;
			clr_int <= 1'b0;
			rf_load <= '0;
			mem.req <= 1'b0;
			mem.write <= 1'b0;
		end
		else
		begin
			state <= next_state;
			step <= next_step;
			rx_pend_q <= next_rx_pend;
			tx_req <= next_tx_req;
			rx_ack <= next_rx_ack;
			tx_resp_ack <= next_tx_resp_ack;
			clr_int <= next_clr_int;
			rf_load <= next_rf_load;
			mem.req <= next_mem_req;
			mem.write <= next_mem_we;
		end
	end

	// Message and data buffers
	always_ff @(posedge CLK)
	begin
		rx_buf <= next_rx_buf;
		tx_addr <= next_tx_addr;
		tx_data <= next_tx_data;
		rf_dout <= next_rf_dout;
		mem.addr <= next_mem_addr;
		mem.wdata <= next_mem_wdata;
	end

	always_comb
	begin
		next_state = state;
		next_step = step;
		next_rx_pend = rx_pend_q;
		next_rx_buf = rx_buf;
		next_tx_addr = tx_addr;
		next_tx_data = tx_data;
		next_tx_req = tx_req;
		next_rx_ack = rx_ack;
		next_tx_resp_ack = tx_resp_ack;
		next_clr_int = clr_int;
		next_rf_dout = rf_dout;
		next_rf_load = '0;
		next_mem_addr = mem.addr;
		next_mem_wdata = mem.wdata;
		next_mem_req = mem.req;
		next_mem_we = mem.write;

		// Strobe releases apply in every state
		if (rx_ack && !(rx_req || rx_fail))
			next_rx_ack = 1'b0;
		if (clr_int && !interrupt)
			next_clr_int = 1'b0;
		if (tx_req && tx_ack)
			next_tx_req = 1'b0;
		if (tx_resp_ack && !(tx_succ || tx_fail))
			next_tx_resp_ack = 1'b0;
		if (mem.req && mem.ack)
			next_mem_req = 1'b0;

		case (state)
			st_idle:
			begin
				next_step = step_addr;
				if (interrupt && !clr_int)
				begin
					next_state = st_int;
					next_clr_int = 1'b1;
				end
				else
				begin
					if (rx_req || rx_fail)
						next_rx_ack = 1'b1;
					// Only a fresh word is decoded
					if (rx_req && !rx_ack)
					begin
						next_rx_buf = rx_data;
						next_rx_pend = rx_pend;
						case (rx_func)
							`LC_CMD_RF_READ: next_state = st_rf_read;
							`LC_CMD_RF_WRITE: next_state = st_rf_write;
							`LC_CMD_MEM_READ: next_state = st_mem_read;
							`LC_CMD_MEM_WRITE: next_state = st_mem_write;
							`LC_CMD_MEM_DMA_WRITE: next_state = st_dma_write;
							default: next_state = st_idle;
						endcase
					end
				end
			end

			st_rf_read:
			begin
				if (rf_idx_ok)
				begin
					next_tx_addr = mbus_addr_t'(`CHANNEL_MEMBER_EVENT);
					next_tx_data = mbus_data_t'(rf_rd_val);
					next_tx_req = 1'b1;
					next_state = st_bus_tx;
				end
				else
					next_state = st_idle;
			end

			st_rf_write:
			begin
				next_rf_dout = rx_buf[`LC_RF_DATA_WIDTH-1:0];
				next_rf_load = rf_load_t'(1) << rf_idx;
				next_state = st_idle;
			end

			st_mem_read:
			begin
				case (step)
					step_addr:
					begin
						// A single-word read must close the message
						if (!rx_pend_q)
						begin
							next_mem_addr = rx_buf[`LC_MEM_ADDR_WIDTH-1:0];
							if (!mem.req && !mem.ack)
							begin
								next_mem_req = 1'b1;
								next_mem_we = 1'b0;
								next_step = step_ack;
							end
						end
						else
							next_state = st_idle;
					end
					default:
					begin
						if (mem.ack)
						begin
							next_tx_addr = mbus_addr_t'(`CHANNEL_MEMBER_EVENT);
							next_tx_data = mbus_data_t'(mem.rdata);
							next_tx_req = 1'b1;
							next_state = st_bus_tx;
						end
					end
				endcase
			end

			st_mem_write, st_dma_write:
			begin
				case (step)
					step_addr:
					begin
						if (rx_pend_q)
						begin
							next_mem_addr = rx_buf[`LC_MEM_ADDR_WIDTH-1:0];
							next_step = step_data;
						end
						else
							next_state = st_idle;
					end
					step_data:
					begin
						if (rx_req && !rx_ack)
						begin
							next_rx_ack = 1'b1;
							next_mem_wdata = mem_data_t'(rx_data);
							next_rx_pend = rx_pend;
							next_step = step_req;
						end
					end
					step_req:
					begin
						// A single write takes exactly one data word
						if (state == st_mem_write && rx_pend_q)
							next_state = st_idle;
						else if (!mem.req && !mem.ack)
						begin
							next_mem_req = 1'b1;
							next_mem_we = 1'b1;
							next_step = step_ack;
						end
					end
					default:
					begin
						if (mem.ack)
						begin
							// Burst stops at the last word or the top address
							if (state == st_dma_write && rx_pend_q &&
								mem.addr < mem_addr_t'(`LC_MEM_DEPTH-1))
							begin
								next_mem_addr = mem.addr + 1'b1;
								next_step = step_data;
							end
							else
								next_state = st_idle;
						end
					end
				endcase
			end

			st_bus_tx:
			begin
				if (tx_ack)
					next_state = st_wait_cpl;
			end

			st_wait_cpl:
			begin
				if (tx_succ || tx_fail)
				begin
					next_tx_resp_ack = 1'b1;
					next_state = st_idle;
				end
			end

			st_int:
			begin
				next_tx_addr = mbus_addr_t'(`CHANNEL_MEMBER_EVENT);
				next_tx_data = {4'h0, short_addr, {`LC_RF_DATA_WIDTH{1'b1}}};
				next_tx_req = 1'b1;
				next_state = st_bus_tx;
			end

			default:
				next_state = st_idle;
		endcase
	end

endmodule

//--- source/layer_regfile.sv
`timescale 1ns/1ps
`include "lc_consts.svh"

module layer_regfile import layer_pkg::*; (
	input logic CLK,
	input logic MEM_ACK_RSTn,
	input rf_data_t rf_dout,
	input rf_load_t rf_load,
	output rf_bank_t rf_din
);

	// Register i sits in slice i of the packed bank
	always_ff @(posedge CLK or negedge MEM_ACK_RSTn)
	begin
		if (!MEM_ACK_RSTn)
			rf_din <= '0;
		else
		begin
			for (int i = 0; i < `LC_RF_DEPTH; i++)
			begin
				if (rf_load[i])
					rf_din[i*`LC_RF_DATA_WIDTH +: `LC_RF_DATA_WIDTH] <= rf_dout;
			end
		end
	end

endmodule

//--- source/layer_mem.sv
`timescale 1ns/1ps
`include "lc_consts.svh"

module layer_mem import layer_pkg::*; (
	input logic CLK,
	input logic MEM_ACK_RSTn,
	mem_port_if.mem mem
);

	mem_data_t mem_array [0:`LC_MEM_DEPTH-1];
	logic ready;
	logic take;

	// One access per request, ready comes back once req drops
	assign take = mem.req & ready;

	always_ff @(posedge CLK or negedge MEM_ACK_RSTn)
	begin
		if (!MEM_ACK_RSTn)
		begin
			mem.ack <= 1'b0;
			ready <= 1'b1;
		end
		else
		begin
			mem.ack <= take;
			if (take)
				ready <= 1'b0;
			else if (!mem.req)
				ready <= 1'b1;
		end
	end

	// Access happens on the same edge that raises ack
	always_ff @(posedge CLK)
	begin
		if (take)
		begin
			if (mem.write)
				mem_array[mem.addr] <= mem.wdata;
			else
				mem.rdata <= mem_array[mem.addr];
		end
	end

endmodule

//--- source/layer_top.sv
`timescale 1ns/1ps

module layer_top import mbus_pkg::*, layer_pkg::*; (
	input logic CLK,
	input logic MEM_ACK_RSTn,
	output mbus_addr_t tx_addr,
	output mbus_data_t tx_data,
	output logic tx_pend,
	output logic tx_req,
	input logic tx_ack,
	input mbus_addr_t rx_addr,
	input mbus_data_t rx_data,
	input logic rx_pend,
	input logic rx_req,
	output logic rx_ack,
	input logic rx_fail,
	input logic tx_succ,
	input logic tx_fail,
	output logic tx_resp_ack,
	input logic interrupt,
	output logic clr_int,
	input func_id_t short_addr
);

	rf_bank_t rf_din;
	rf_data_t rf_dout;
	rf_load_t rf_load;

	mem_port_if mem_bus ();

	layer_ctrl u_ctrl (
		.CLK(CLK),
		.MEM_ACK_RSTn(MEM_ACK_RSTn),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_pend(tx_pend),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.rx_pend(rx_pend),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.rx_fail(rx_fail),
		.tx_succ(tx_succ),
		.tx_fail(tx_fail),
		.tx_resp_ack(tx_resp_ack),
		.rf_din(rf_din),
		.rf_dout(rf_dout),
		.rf_load(rf_load),
		.mem(mem_bus.ctrl),
		.interrupt(interrupt),
		.clr_int(clr_int),
		.short_addr(short_addr)
	);

	layer_regfile u_regfile (
		.CLK(CLK),
		.MEM_ACK_RSTn(MEM_ACK_RSTn),
		.rf_dout(rf_dout),
		.rf_load(rf_load),
		.rf_din(rf_din)
	);

	layer_mem u_mem (
		.CLK(CLK),
		.MEM_ACK_RSTn(MEM_ACK_RSTn),
		.mem(mem_bus.mem)
	);

endmodule

//--- sim/tb_layer_top.sv
`timescale 1ns/1ps
`include "lc_consts.svh"

module tb_layer_top import mbus_pkg::*; ();

	localparam int MAX_ROWS = 24;
	localparam int MAX_WORDS = 5;
	localparam int WAIT_LIMIT = 40;
	localparam int SEL_RX_ACK = 0;
	localparam int SEL_TX_REQ = 1;
	localparam int SEL_RESP_ACK = 2;
	localparam int SEL_CLR_INT = 3;

	logic CLK;
	logic MEM_ACK_RSTn;
	mbus_addr_t tx_addr;
	mbus_data_t tx_data;
	logic tx_pend;
	logic tx_req;
	logic tx_ack;
	mbus_addr_t rx_addr;
	mbus_data_t rx_data;
	logic rx_pend;
	logic rx_req;
	logic rx_ack;
	logic rx_fail;
	logic tx_succ;
	logic tx_fail;
	logic tx_resp_ack;
	logic interrupt;
	logic clr_int;
	func_id_t short_addr;

	// Stimulus table, one command per row
	logic [3:0] row_cmd [0:MAX_ROWS-1];
	int row_nw [0:MAX_ROWS-1];
	mbus_data_t row_word [0:MAX_ROWS-1][0:MAX_WORDS-1];
	logic row_pend [0:MAX_ROWS-1][0:MAX_WORDS-1];
	logic row_irq [0:MAX_ROWS-1];
	logic row_reply [0:MAX_ROWS-1];
	logic row_fail [0:MAX_ROWS-1];
	mbus_data_t row_exp [0:MAX_ROWS-1];
	int n_rows;

	int value_errors;
	int timeouts;
	int other_errors;
	int unsigned seed_dummy;
	int r;
	int w;

	// Random test values
	logic [7:0] k;
	logic [23:0] v1;
	logic [23:0] v2;
	logic [5:0] a;
	mbus_data_t m1;
	mbus_data_t m2;
	mbus_data_t d [0:3];
	mbus_data_t e0;
	mbus_data_t e1;
	func_id_t sa;

	layer_top UUT (.*);

	always #2 CLK = ~CLK;

	function automatic logic probe(input int sel);
		case (sel)
			SEL_RX_ACK: return rx_ack;
			SEL_TX_REQ: return tx_req;
			SEL_RESP_ACK: return tx_resp_ack;
			default: return clr_int;
		endcase
	endfunction

	task automatic wait_signal(input int sel, input logic level, input string name);
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (probe(sel) !== level && cycles < WAIT_LIMIT)
		begin
			@(negedge CLK);
			cycles++;
		end
		assert (probe(sel) === level)
		else
		begin
			timeouts++;
			$display("Timeout at %0t ns: %s did not go to %0b", $time, name, level);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
		else
		begin
			value_errors++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic new_row(input logic [3:0] cmd, input logic irq, input logic reply,
		input logic use_fail, input mbus_data_t exp);
		row_cmd[n_rows] = cmd;
		row_nw[n_rows] = 0;
		row_irq[n_rows] = irq;
		row_reply[n_rows] = reply;
		row_fail[n_rows] = use_fail;
		row_exp[n_rows] = exp;
		n_rows++;
	endtask

	// Appends a word to the newest row
	task automatic push_word(input mbus_data_t word, input logic pend);
		row_word[n_rows-1][row_nw[n_rows-1]] = word;
		row_pend[n_rows-1][row_nw[n_rows-1]] = pend;
		row_nw[n_rows-1]++;
	endtask

	task automatic build_table();
		int i;
		k = 8'(2 + $urandom % 6);
		v1 = 24'($urandom);
		v2 = 24'($urandom);
		a = 6'(20 + $urandom % 30);
		m1 = $urandom;
		m2 = $urandom;
		for (i = 0; i < 4; i++)
			d[i] = $urandom;
		e0 = $urandom;
		e1 = $urandom;
		n_rows = 0;

		// Register write and read back
		new_row(`LC_CMD_RF_WRITE, 1'b0, 1'b0, 1'b0, '0);
		push_word({k, v1}, 1'b0);
		new_row(`LC_CMD_RF_READ, 1'b0, 1'b1, 1'b0, {8'h00, v1});
		push_word({k, 24'h0}, 1'b0);
		// Index 9 lands in register 1
		new_row(`LC_CMD_RF_WRITE, 1'b0, 1'b0, 1'b0, '0);
		push_word({8'd9, v2}, 1'b0);
		new_row(`LC_CMD_RF_READ, 1'b0, 1'b1, 1'b0, {8'h00, v2});
		push_word({8'd1, 24'h0}, 1'b0);
		// Out of range read is dropped
		new_row(`LC_CMD_RF_READ, 1'b0, 1'b0, 1'b0, '0);
		push_word({8'd12, 24'h0}, 1'b0);
		new_row(`LC_CMD_RF_READ, 1'b0, 1'b1, 1'b0, {8'h00, v1});
		push_word({k, 24'h0}, 1'b0);

		// Single word write, read back closed with tx_fail
		new_row(`LC_CMD_MEM_WRITE, 1'b0, 1'b0, 1'b0, '0);
		push_word(32'(a), 1'b1);
		push_word(m1, 1'b0);
		new_row(`LC_CMD_MEM_READ, 1'b0, 1'b1, 1'b1, m1);
		push_word(32'(a), 1'b0);

		// Four word burst from address 10
		new_row(`LC_CMD_MEM_DMA_WRITE, 1'b0, 1'b0, 1'b0, '0);
		push_word(32'd10, 1'b1);
		for (i = 0; i < 4; i++)
			push_word(d[i], i < 3);
		for (i = 0; i < 4; i++)
		begin
			new_row(`LC_CMD_MEM_READ, 1'b0, 1'b1, i % 2 == 1, d[i]);
			push_word(32'(10 + i), 1'b0);
		end

		// Address 0 shows whether a burst wraps
		new_row(`LC_CMD_MEM_WRITE, 1'b0, 1'b0, 1'b0, '0);
		push_word(32'd0, 1'b1);
		push_word(m2, 1'b0);
		new_row(`LC_CMD_MEM_DMA_WRITE, 1'b0, 1'b0, 1'b0, '0);
		push_word(32'd62, 1'b1);
		push_word(e0, 1'b1);
		push_word(e1, 1'b1);
		new_row(`LC_CMD_MEM_READ, 1'b0, 1'b1, 1'b0, e0);
		push_word(32'd62, 1'b0);
		new_row(`LC_CMD_MEM_READ, 1'b0, 1'b1, 1'b0, e1);
		push_word(32'd63, 1'b0);
		new_row(`LC_CMD_MEM_READ, 1'b0, 1'b1, 1'b0, m2);
		push_word(32'd0, 1'b0);

		// Event message, then an unknown code
		new_row(4'd0, 1'b1, 1'b1, 1'b0, {4'h0, sa, 24'hFFFFFF});
		new_row(4'd7, 1'b0, 1'b0, 1'b0, '0);
		push_word($urandom, 1'b0);
		new_row(`LC_CMD_RF_READ, 1'b0, 1'b1, 1'b1, {8'h00, v1});
		push_word({k, 24'h0}, 1'b0);
	endtask

	task automatic send_word(input logic [3:0] cmd, input mbus_data_t word,
		input logic pend);
		@(posedge CLK);
		rx_addr <= {28'h0, cmd};
		rx_data <= word;
		rx_pend <= pend;
		rx_req <= 1'b1;
		wait_signal(SEL_RX_ACK, 1'b1, "rx_ack");
		@(posedge CLK);
		rx_req <= 1'b0;
		wait_signal(SEL_RX_ACK, 1'b0, "rx_ack");
	endtask

	task automatic check_reply(input mbus_data_t exp);
		wait_signal(SEL_TX_REQ, 1'b1, "tx_req");
		check_value("tx_addr", 32'(`CHANNEL_MEMBER_EVENT), tx_addr);
		check_value("tx_data", exp, tx_data);
		check_value("tx_pend", 32'h0, {31'h0, tx_pend});
		@(posedge CLK);
		tx_ack <= 1'b1;
		wait_signal(SEL_TX_REQ, 1'b0, "tx_req");
		@(posedge CLK);
		tx_ack <= 1'b0;
	endtask

	task automatic complete_reply(input logic use_fail);
		@(posedge CLK);
		if (use_fail)
			tx_fail <= 1'b1;
		else
			tx_succ <= 1'b1;
		wait_signal(SEL_RESP_ACK, 1'b1, "tx_resp_ack");
		@(posedge CLK);
		tx_succ <= 1'b0;
		tx_fail <= 1'b0;
		wait_signal(SEL_RESP_ACK, 1'b0, "tx_resp_ack");
	endtask

	task automatic raise_interrupt();
		@(posedge CLK);
		interrupt <= 1'b1;
		wait_signal(SEL_CLR_INT, 1'b1, "clr_int");
		@(posedge CLK);
		interrupt <= 1'b0;
		wait_signal(SEL_CLR_INT, 1'b0, "clr_int");
	endtask

	task automatic expect_silence();
		logic seen;
		seen = 1'b0;
		repeat (WAIT_LIMIT)
		begin
			@(negedge CLK);
			if (tx_req)
				seen = 1'b1;
		end
		assert (!seen)
		else
		begin
			other_errors++;
			$display("Unexpected reply at %0t ns: tx_req rose on a command with no reply",
				$time);
		end
	endtask

	initial
	begin
		seed_dummy = $urandom(10192);
		value_errors = 0;
		timeouts = 0;
		other_errors = 0;
		CLK = 1'b0;
		MEM_ACK_RSTn = 1'b0;
		tx_ack = 1'b0;
		rx_addr = '0;
		rx_data = '0;
		rx_pend = 1'b0;
		rx_req = 1'b0;
		rx_fail = 1'b0;
		tx_succ = 1'b0;
		tx_fail = 1'b0;
		interrupt = 1'b0;
		sa = func_id_t'($urandom % 16);
		short_addr = sa;
		build_table();

		repeat (10) @(posedge CLK);
		MEM_ACK_RSTn <= 1'b1;
		@(negedge CLK);
		check_value("tx_req", 32'h0, {31'h0, tx_req});
		check_value("rx_ack", 32'h0, {31'h0, rx_ack});
		check_value("tx_resp_ack", 32'h0, {31'h0, tx_resp_ack});
		check_value("clr_int", 32'h0, {31'h0, clr_int});

		for (r = 0; r < n_rows; r++)
		begin
			if (row_irq[r])
				raise_interrupt();
			else
				for (w = 0; w < row_nw[r]; w++)
					send_word(row_cmd[r], row_word[r][w], row_pend[r][w]);
			if (row_reply[r])
			begin
				check_reply(row_exp[r]);
				complete_reply(row_fail[r]);
			end
			else
				expect_silence();
		end

		$display("Value errors %0d, timeouts %0d, other errors %0d",
			value_errors, timeouts, other_errors);
		if (value_errors == 0 && timeouts == 0 && other_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- project.f
+incdir+source
source/mbus_pkg.sv
source/layer_pkg.sv
source/mem_port_if.sv
source/layer_ctrl.sv
source/layer_regfile.sv
source/layer_mem.sv
source/layer_top.sv
sim/tb_layer_top.sv
